// File: aluUnit.sv
`timescale 1ns/1ps

module aluUnit (
    input  logic [cpuPkg::dataWidth-1:0] a,
    input  logic [cpuPkg::dataWidth-1:0] b,
    input  cpuPkg::aluSel_e              aluSel,
    output logic [cpuPkg::dataWidth-1:0] result,
    output logic [3:0]                   flagsNext
);
    import cpuPkg::*;

    logic [dataWidth:0] sum;
    logic [dataWidth:0] diff;
    logic               carry;
    logic               overflow;

    assign sum  = {1'b0, a} + {1'b0, b};
    // carry out set means no borrow
    assign diff = {1'b0, a} + {1'b0, ~b} + 1'b1;

    always_comb begin
        carry    = 1'b0;
        overflow = 1'b0;
        case (aluSel)
            aluAdd: begin
                result   = sum[dataWidth-1:0];
                carry    = sum[dataWidth];
                overflow = (a[dataWidth-1] == b[dataWidth-1])
                         && (result[dataWidth-1] != a[dataWidth-1]);
            end
            aluSub: begin
                result   = diff[dataWidth-1:0];
                carry    = diff[dataWidth];
                overflow = (a[dataWidth-1] != b[dataWidth-1])
                         && (result[dataWidth-1] != a[dataWidth-1]);
            end
            // low half of the product only
            aluMul:  result = a * b;
            aluLsr:  result = a >> b[$clog2(dataWidth)-1:0];
            aluAnd:  result = a & b;
            aluOr:   result = a | b;
            aluMvn:  result = ~a;
            default: result = a;
        endcase
    end

    assign flagsNext = {result[dataWidth-1], result == '0, carry, overflow};

endmodule

// File: controlLogic.sv
`timescale 1ns/1ps

module controlLogic (
    input  logic [cpuPkg::numStates-1:0] cpuState,
    input  logic                         flagN,
    input  logic                         flagZ,
    input  logic                         flagC,
    input  logic                         flagV,
    output logic                         rselLoad,
    output logic                         rop1Load,
    output logic                         rop2Load,
    output logic                         trLoad,
    output logic                         arLoad,
    output logic                         pcLoad,
    output logic                         drLoad,
    output logic                         acLoad,
    output logic                         irLoad,
    output logic                         gprLoad,
    output logic                         memLoad,
    output logic                         pcInc,
    output logic                         counterLd,
    output logic                         counterInc,
    output logic                         counterClr,
    output cpuPkg::aluSel_e              aluSel,
    output cpuPkg::busSel_e              busSel
);
    import cpuPkg::*;

    logic                 stateValid;
    logic [numStates-1:0] st;
    logic                 takeBgt;
    logic                 takeBlt;
    logic                 takeBeq;

    // a vector that is not one-hot drives nothing
    assign stateValid = $onehot(cpuState);
    assign st         = stateValid ? cpuState : '0;

    // conditions on the flags left by the last cmp
    assign takeBgt = ~flagZ & (flagN == flagV);
    assign takeBlt = flagN != flagV;
    assign takeBeq = flagZ;

    // fetch3 latches the decoded fields and jumps to the routine
    assign irLoad    = st[fetch3];
    assign rselLoad  = st[fetch3];
    assign rop1Load  = st[fetch3];
    assign rop2Load  = st[fetch3];
    assign counterLd = st[fetch3];
    assign pcInc     = st[fetch2];

    assign arLoad  = st[fetch1] | st[ldr1] | st[altLdr1] | st[str1] | st[altStr1];
    assign drLoad  = st[fetch2] | st[altLdr2] | st[str3] | st[altStr3];
    assign trLoad  = st[altMov1] | st[altLdr3] | st[str2] | st[altStr2];
    assign acLoad  = st[cmp1] | st[add1] | st[sub1] | st[mul1] | st[lsr1]
                   | st[and1] | st[or1] | st[mvn1];
    assign gprLoad = st[mov1] | st[altMov2] | st[ldr2] | st[altLdr4]
                   | st[add2] | st[sub2] | st[mul2] | st[lsr2]
                   | st[and2] | st[or2] | st[mvn2];
    assign memLoad = st[str4] | st[altStr4];

    // untaken branches just fall through to the next fetch
    assign pcLoad = st[b1] | (st[bgt1] & takeBgt) | (st[blt1] & takeBlt)
                  | (st[beq1] & takeBeq);

    // step inside a routine
    assign counterInc = st[fetch1] | st[fetch2] | st[altMov1] | st[ldr1]
                      | st[altLdr1] | st[altLdr2] | st[altLdr3]
                      | st[str1] | st[str2] | st[str3]
                      | st[altStr1] | st[altStr2] | st[altStr3]
                      | st[add1] | st[sub1] | st[mul1] | st[lsr1]
                      | st[and1] | st[or1] | st[mvn1];

    // last state of every routine goes back to fetch1
    assign counterClr = st[nop1] | st[mov1] | st[altMov2] | st[ldr2] | st[altLdr4]
                      | st[str4] | st[altStr4] | st[cmp1]
                      | st[b1] | st[bgt1] | st[blt1] | st[beq1]
                      | st[add2] | st[sub2] | st[mul2] | st[lsr2]
                      | st[and2] | st[or2] | st[mvn2];

    always_comb begin
        case (1'b1)
            st[fetch2], st[ldr2], st[altLdr2]: busSel = busMem;
            st[fetch3], st[altLdr3], st[str4], st[altStr4]: busSel = busDr;
            st[altMov2], st[altLdr4], st[str3], st[altStr3]: busSel = busTr;
            st[altLdr1], st[altStr1]: busSel = busRop1;
            st[altMov1], st[str2], st[altStr2]: busSel = busGpr1;
            // immediate operand for moves, addresses and branch targets
            st[mov1], st[ldr1], st[str1],
            st[b1], st[bgt1], st[blt1], st[beq1]: busSel = busRop2;
            st[add2], st[sub2], st[mul2], st[lsr2],
            st[and2], st[or2], st[mvn2]: busSel = busAc;
            default: busSel = busPc;
        endcase
    end

    always_comb begin
        case (1'b1)
            st[add1]: aluSel = aluAdd;
            // cmp is a subtract that only keeps the flags
            st[sub1], st[cmp1]: aluSel = aluSub;
            st[mul1]: aluSel = aluMul;
            st[lsr1]: aluSel = aluLsr;
            st[and1]: aluSel = aluAnd;
            st[or1]: aluSel = aluOr;
            st[mvn1]: aluSel = aluMvn;
            default: aluSel = aluPass;
        endcase
    end

    // halt1 falls into every default above and so raises nothing

endmodule

// File: cpuPkg.sv
package cpuPkg;

    // machine word and memory address
    localparam int dataWidth     = 16;
    localparam int addrWidth     = 8;

    // micro-sequencer sizing, 40 routine states plus halt1
    localparam int numStates     = 41;
    localparam int stateIdxWidth = 6;

    // ALT forms take their address or source from a register
    typedef enum logic [4:0] {
        opNop = 5'd0,
        opMov, opAltMov,
        opLdr, opAltLdr,
        opStr, opAltStr,
        opCmp,
        opB, opBgt, opBlt, opBeq,
        opAdd, opSub, opMul, opLsr, opAnd, opOr, opMvn,
        opHalt
    } opcode_e;

    // counter values, each routine starts at its first entry
    typedef enum logic [stateIdxWidth-1:0] {
        fetch1 = 6'd0, fetch2, fetch3,
        nop1,
        mov1,
        altMov1, altMov2,
        ldr1, ldr2,
        altLdr1, altLdr2, altLdr3, altLdr4,
        str1, str2, str3, str4,
        altStr1, altStr2, altStr3, altStr4,
        cmp1,
        b1, bgt1, blt1, beq1,
        add1, add2, sub1, sub2, mul1, mul2, lsr1, lsr2,
        and1, and2, or1, or2, mvn1, mvn2,
        halt1
    } stateIdx_e;

    typedef enum logic [3:0] {
        busPc = 4'd0, busDr, busAr, busAc, busMem, busTr, busRop1, busRop2, busGpr1
    } busSel_e;

    typedef enum logic [2:0] {
        aluAdd = 3'd0, aluSub, aluMul, aluLsr, aluAnd, aluOr, aluMvn, aluPass
    } aluSel_e;

    // register form for ALU ops and ALT forms, immediate form for the rest
    typedef union packed {
        struct packed {
            opcode_e    opcode;
            logic [2:0] rd;
            logic [2:0] rs1;
            logic [2:0] rs2;
            logic [1:0] spare;
        } regForm;
        struct packed {
            opcode_e    opcode;
            logic [2:0] rd;
            logic [7:0] imm;
        } immForm;
    } instrWord_u;

endpackage

// File: cpuTop.sv
`timescale 1ns/1ps

module cpuTop (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         run,
    output logic                         halted,
    input  logic                         pSel,
    input  logic                         pEnable,
    input  logic                         pWrite,
    input  logic [cpuPkg::addrWidth-1:0] pAddr,
    input  logic [cpuPkg::dataWidth-1:0] pWData,
    output logic [cpuPkg::dataWidth-1:0] pRData,
    output logic                         pReady
);
    import cpuPkg::*;

    // sequencer and control strobes
    logic [numStates-1:0] cpuState;
    logic                 counterLd;
    logic                 counterInc;
    logic                 counterClr;
    logic                 rselLoad;
    logic                 rop1Load;
    logic                 rop2Load;
    logic                 trLoad;
    logic                 arLoad;
    logic                 pcLoad;
    logic                 drLoad;
    logic                 acLoad;
    logic                 irLoad;
    logic                 gprLoad;
    logic                 memLoad;
    logic                 pcInc;
    aluSel_e              aluSel;
    busSel_e              busSel;

    // datapath and memory
    logic                 flagN;
    logic                 flagZ;
    logic                 flagC;
    logic                 flagV;
    opcode_e              opcode;
    logic [addrWidth-1:0] address;
    logic [dataWidth-1:0] bus;
    logic [dataWidth-1:0] memData;

    // port names match the wires one for one
    stateSequencer seq0 (.*);

    controlLogic ctrl0 (.*);

    dataPath dp0 (.*);

    mainMemory mem0 (.*);

endmodule

// File: dataPath.sv
`timescale 1ns/1ps

module dataPath (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         rselLoad,
    input  logic                         rop1Load,
    input  logic                         rop2Load,
    input  logic                         trLoad,
    input  logic                         arLoad,
    input  logic                         pcLoad,
    input  logic                         drLoad,
    input  logic                         acLoad,
    input  logic                         irLoad,
    input  logic                         gprLoad,
    input  logic                         pcInc,
    input  cpuPkg::aluSel_e              aluSel,
    input  cpuPkg::busSel_e              busSel,
    input  logic [cpuPkg::dataWidth-1:0] memData,
    output cpuPkg::opcode_e              opcode,
    output logic [cpuPkg::addrWidth-1:0] address,
    output logic [cpuPkg::dataWidth-1:0] bus,
    output logic                         flagN,
    output logic                         flagZ,
    output logic                         flagC,
    output logic                         flagV
);
    import cpuPkg::*;

    logic [addrWidth-1:0] pc;
    logic [addrWidth-1:0] ar;
    logic [dataWidth-1:0] dr;
    logic [dataWidth-1:0] tr;
    logic [dataWidth-1:0] ac;
    logic [dataWidth-1:0] rop1;
    logic [dataWidth-1:0] rop2;
    logic [dataWidth-1:0] rop2Next;
    logic [2:0]           rsel;
    logic [2:0]           gpr1Idx;
    logic [dataWidth-1:0] gpr [0:7];
    instrWord_u           ir;
    instrWord_u           drWord;
    logic [dataWidth-1:0] aluResult;
    logic [3:0]           aluFlags;

    aluUnit alu0 (
        .a         (rop1),
        .b         (rop2),
        .aluSel    (aluSel),
        .result    (aluResult),
        .flagsNext (aluFlags)
    );

    // DR holds the fetched word during fetch3
    assign drWord  = dr;
    assign opcode  = drWord.immForm.opcode;
    assign address = ar;

    // immediate forms feed imm as the second operand
    always_comb begin
        case (drWord.regForm.opcode)
            opMov, opLdr, opStr, opB, opBgt, opBlt, opBeq: begin
                rop2Next = dataWidth'(drWord.immForm.imm);
            end
            default: begin
                rop2Next = gpr[drWord.regForm.rs2];
            end
        endcase
    end

    // ALT mov copies from rs1, stores read back rd
    assign gpr1Idx = (ir.regForm.opcode == opAltMov) ? ir.regForm.rs1 : rsel;

    // system bus
    always_comb begin
        case (busSel)
            busPc:   bus = dataWidth'(pc);
            busDr:   bus = dr;
            busAr:   bus = dataWidth'(ar);
            busAc:   bus = ac;
            busMem:  bus = memData;
            busTr:   bus = tr;
            busRop1: bus = rop1;
            busRop2: bus = rop2;
            busGpr1: bus = gpr[gpr1Idx];
            default: bus = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= '0;
            {flagN, flagZ, flagC, flagV} <= 4'b0000;
        end else begin
            if (pcLoad) begin
                pc <= bus[addrWidth-1:0];
            end else if (pcInc) begin
                pc <= pc + 1'b1;
            end
            // flags only move with AC
            if (acLoad) begin
                {flagN, flagZ, flagC, flagV} <= aluFlags;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (arLoad) ar <= bus[addrWidth-1:0];
        if (drLoad) dr <= bus;
        if (trLoad) tr <= bus;
        if (acLoad) ac <= aluResult;
        if (irLoad) ir <= bus;
        if (rselLoad) rsel <= drWord.immForm.rd;
        if (rop1Load) rop1 <= gpr[drWord.regForm.rs1];
        if (rop2Load) rop2 <= rop2Next;
        if (gprLoad) gpr[rsel] <= bus;
    end

endmodule

// File: list.f
cpuPkg.sv
aluUnit.sv
controlLogic.sv
stateSequencer.sv
dataPath.sv
mainMemory.sv
cpuTop.sv
tbChecker.sv
tbCpu.sv

// File: mainMemory.sv
`timescale 1ns/1ps

module mainMemory (
    input  logic                         clk,
    input  logic                         reset,
    input  logic [cpuPkg::addrWidth-1:0] address,
    input  logic [cpuPkg::dataWidth-1:0] bus,
    input  logic                         memLoad,
    input  logic                         pSel,
    input  logic                         pEnable,
    input  logic                         pWrite,
    input  logic [cpuPkg::addrWidth-1:0] pAddr,
    input  logic [cpuPkg::dataWidth-1:0] pWData,
    output logic [cpuPkg::dataWidth-1:0] memData,
    output logic [cpuPkg::dataWidth-1:0] pRData,
    output logic                         pReady
);
    import cpuPkg::*;

    logic [dataWidth-1:0] mem [0:(2**addrWidth)-1];
    logic                 apbSetupRead;
    logic                 apbAccessWrite;

    assign apbSetupRead   = pSel & ~pEnable & ~pWrite;
    assign apbAccessWrite = pSel & pEnable & pWrite;

    // CPU side reads straight through at AR
    assign memData = mem[address];

    // no wait states
    assign pReady = 1'b1;

    // APB only runs while the CPU is stopped, so the two never collide
    always_ff @(posedge clk) begin
        if (apbAccessWrite) begin
            mem[pAddr] <= pWData;
        end else if (memLoad) begin
            mem[address] <= bus;
        end
    end

    // captured in setup, held through the access phase
    always_ff @(posedge clk) begin
        if (reset) begin
            pRData <= '0;
        end else if (apbSetupRead) begin
            pRData <= mem[pAddr];
        end
    end

endmodule

// File: run.sh
#!/usr/bin/env bash
# build and run the CPU testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module tbCpu -f list.f -Mdir obj_dir -o simCpu
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/simCpu)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "TEST RESULT: PASS"; then
    exit 0
fi
exit 1

// File: stateSequencer.sv
`timescale 1ns/1ps

module stateSequencer (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         run,
    input  cpuPkg::opcode_e              opcode,
    input  logic                         counterLd,
    input  logic                         counterInc,
    input  logic                         counterClr,
    output logic [cpuPkg::numStates-1:0] cpuState,
    output logic                         halted
);
    import cpuPkg::*;

    stateIdx_e            stateIdx;
    stateIdx_e            startIdx;
    logic [numStates-1:0] oneHot;

    // first state of each routine
    always_comb begin
        case (opcode)
            opNop:    startIdx = nop1;
            opMov:    startIdx = mov1;
            opAltMov: startIdx = altMov1;
            opLdr:    startIdx = ldr1;
            opAltLdr: startIdx = altLdr1;
            opStr:    startIdx = str1;
            opAltStr: startIdx = altStr1;
            opCmp:    startIdx = cmp1;
            opB:      startIdx = b1;
            opBgt:    startIdx = bgt1;
            opBlt:    startIdx = blt1;
            opBeq:    startIdx = beq1;
            opAdd:    startIdx = add1;
            opSub:    startIdx = sub1;
            opMul:    startIdx = mul1;
            opLsr:    startIdx = lsr1;
            opAnd:    startIdx = and1;
            opOr:     startIdx = or1;
            opMvn:    startIdx = mvn1;
            opHalt:   startIdx = halt1;
            // unused encodings run as nop
            default:  startIdx = nop1;
        endcase
    end

    // frozen while stopped or once halt1 is reached
    always_ff @(posedge clk) begin
        if (reset) begin
            stateIdx <= fetch1;
        end else if (run && !halted) begin
            if (counterClr) begin
                stateIdx <= fetch1;
            end else if (counterLd) begin
                stateIdx <= startIdx;
            end else if (counterInc) begin
                stateIdx <= stateIdx_e'(stateIdx + 1'b1);
            end
        end
    end

    assign halted = (stateIdx == halt1);

    always_comb begin
        oneHot = '0;
        oneHot[stateIdx] = 1'b1;
    end

    // an all-zero vector keeps every strobe low until run
    assign cpuState = run ? oneHot : '0;

endmodule

// File: tbChecker.sv
`timescale 1ns/1ps

module tbChecker (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         halted,
    input  logic                         pSel,
    input  logic                         pEnable,
    input  logic                         pWrite,
    input  logic [cpuPkg::addrWidth-1:0] pAddr,
    input  logic [cpuPkg::dataWidth-1:0] pRData,
    input  logic                         pReady,
    input  int                           testId,
    input  logic [cpuPkg::dataWidth-1:0] expImage [0:(2**cpuPkg::addrWidth)-1],
    output int                           checkCount,
    output int                           dataErrors,
    output int                           otherErrors
);
    import cpuPkg::*;

    int   checks = 0;
    int   badData = 0;
    int   badOther = 0;
    logic prevHalted = 1'b0;

    assign checkCount  = checks;
    assign dataErrors  = badData;
    assign otherErrors = badOther;

    function automatic string testName(input int id);
        case (id)
            0:       return "apbRoundTrip";
            1:       return "moveLoadStore";
            2:       return "aluOps";
            3:       return "compareBranch";
            4:       return "jumpNopHalt";
            default: return "unknown";
        endcase
    endfunction

    always @(posedge clk) begin
        if (pSel && pEnable) begin
            if (!pReady) begin
                $display("pReady was low in an access phase at address 0x%02h", pAddr);
                badOther++;
            end
            // read data was captured in the setup cycle
            if (!pWrite) begin
                checks++;
                if (pRData !== expImage[pAddr]) begin
                    $display("Error %s addr 0x%02h expected 0x%04h actual 0x%04h",
                             testName(testId), pAddr, expImage[pAddr], pRData);
                    badData++;
                end
            end
        end
        // once up, halted only drops through reset
        if (!reset && prevHalted && !halted) begin
            $display("halted fell without a reset during test %s", testName(testId));
            badOther++;
        end
        prevHalted = halted;
    end

endmodule

// File: tbCpu.sv
`timescale 1ns/1ps

module tbCpu;
    import cpuPkg::*;

    localparam int memWords       = 2 ** addrWidth;
    localparam int numTests       = 5;
    localparam int resetCycles    = 10;
    localparam int maxSteps       = 256;
    localparam int cyclesPerInstr = 7;
    // every word written and read once at three cycles per transfer
    localparam int apbCycles      = 2 * memWords * 3;
    localparam int watchdogCycles = numTests * (resetCycles + apbCycles
                                  + maxSteps * cyclesPerInstr + 40) + 500;

    logic                 clk;
    logic                 reset;
    logic                 run;
    logic                 halted;
    logic                 pSel;
    logic                 pEnable;
    logic                 pWrite;
    logic [addrWidth-1:0] pAddr;
    logic [dataWidth-1:0] pWData;
    logic [dataWidth-1:0] pRData;
    logic                 pReady;
    int                   testId;
    int                   checkCount;
    int                   dataErrors;
    int                   otherErrors;
    int                   missingHalts;
    int                   progPos;
    logic [dataWidth-1:0] image [0:memWords-1];
    logic [dataWidth-1:0] expMem [0:memWords-1];

    cpuTop dut0 (
        .clk     (clk),
        .reset   (reset),
        .run     (run),
        .halted  (halted),
        .pSel    (pSel),
        .pEnable (pEnable),
        .pWrite  (pWrite),
        .pAddr   (pAddr),
        .pWData  (pWData),
        .pRData  (pRData),
        .pReady  (pReady)
    );

    tbChecker chk0 (
        .clk         (clk),
        .reset       (reset),
        .halted      (halted),
        .pSel        (pSel),
        .pEnable     (pEnable),
        .pWrite      (pWrite),
        .pAddr       (pAddr),
        .pRData      (pRData),
        .pReady      (pReady),
        .testId      (testId),
        .expImage    (expMem),
        .checkCount  (checkCount),
        .dataErrors  (dataErrors),
        .otherErrors (otherErrors)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        repeat (watchdogCycles) @(posedge clk);
        $display("watchdog expired after %0d cycles, run stopped", watchdogCycles);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    function automatic logic [dataWidth-1:0] immInstr(input opcode_e op,
            input logic [2:0] rd, input logic [7:0] imm);
        instrWord_u w;
        w.immForm.opcode = op;
        w.immForm.rd     = rd;
        w.immForm.imm    = imm;
        return w;
    endfunction

    function automatic logic [dataWidth-1:0] regInstr(input opcode_e op,
            input logic [2:0] rd, input logic [2:0] rs1, input logic [2:0] rs2);
        instrWord_u w;
        w.regForm.opcode = op;
        w.regForm.rd     = rd;
        w.regForm.rs1    = rs1;
        w.regForm.rs2    = rs2;
        w.regForm.spare  = 2'b00;
        return w;
    endfunction

    // result in the low half, NZCV on top
    function automatic logic [19:0] aluRef(input opcode_e op,
            input logic [dataWidth-1:0] a, input logic [dataWidth-1:0] b);
        logic [dataWidth-1:0] res;
        logic                 c;
        logic                 v;
        int                   wide;
        c = 1'b0;
        v = 1'b0;
        case (op)
            opAdd: begin
                res = a + b;
                c = (int'(a) + int'(b)) > 65535;
                // signed sum outside the 16-bit range
                wide = int'($signed(a)) + int'($signed(b));
                v = (wide > 32767) || (wide < -32768);
            end
            opSub, opCmp: begin
                res = a - b;
                c = a >= b;
                wide = int'($signed(a)) - int'($signed(b));
                v = (wide > 32767) || (wide < -32768);
            end
            opMul:   res = a * b;
            opLsr:   res = a >> b[3:0];
            opAnd:   res = a & b;
            opOr:    res = a | b;
            opMvn:   res = ~a;
            default: res = a;
        endcase
        return {res[15], res == 16'h0000, c, v, res};
    endfunction

    // instruction-level model that runs on expMem and returns the instruction count
    function automatic int runModel();
        logic [dataWidth-1:0] r [0:7];
        logic [addrWidth-1:0] pc;
        logic [3:0]           nzcv;
        logic [19:0]          aluOut;
        logic [dataWidth-1:0] a;
        logic [dataWidth-1:0] b;
        logic [7:0]           imm;
        logic [2:0]           rd;
        instrWord_u           w;
        int                   steps;
        logic                 done;
        for (int i = 0; i < 8; i++) begin
            r[3'(i)] = '0;
        end
        pc = '0;
        nzcv = 4'b0000;
        steps = 0;
        done = 1'b0;
        while (!done && steps < maxSteps) begin
            w = expMem[pc];
            pc = pc + 8'd1;
            steps++;
            rd = w.immForm.rd;
            imm = w.immForm.imm;
            a = r[w.regForm.rs1];
            b = r[w.regForm.rs2];
            case (w.regForm.opcode)
                opMov:    r[rd] = {8'h00, imm};
                opAltMov: r[rd] = a;
                opLdr:    r[rd] = expMem[imm];
                opAltLdr: r[rd] = expMem[a[7:0]];
                opStr:    expMem[imm] = r[rd];
                opAltStr: expMem[a[7:0]] = r[rd];
                opB:      pc = imm;
                // nzcv is N Z C V from bit 3 down
                opBgt:    pc = (!nzcv[2] && nzcv[3] == nzcv[0]) ? imm : pc;
                opBlt:    pc = (nzcv[3] != nzcv[0]) ? imm : pc;
                opBeq:    pc = nzcv[2] ? imm : pc;
                opCmp: begin
                    aluOut = aluRef(opCmp, a, b);
                    nzcv = aluOut[19:16];
                end
                opAdd, opSub, opMul, opLsr, opAnd, opOr, opMvn: begin
                    aluOut = aluRef(w.regForm.opcode, a, b);
                    nzcv = aluOut[19:16];
                    r[rd] = aluOut[15:0];
                end
                opHalt:   done = 1'b1;
                default:  ;
            endcase
        end
        return steps;
    endfunction

    task automatic emit(input logic [dataWidth-1:0] word);
        image[addrWidth'(progPos)] = word;
        progPos++;
    endtask

    // mov, ldr and str in both forms with results from 0xC0 up
    task automatic buildMoves();
        logic [7:0] base;
        for (int k = 0; k < 4; k++) begin
            base = 8'(8'hC0 + 8 * k);
            emit(immInstr(opMov, 3'd1, 8'($urandom)));
            emit(immInstr(opStr, 3'd1, base));
            emit(immInstr(opLdr, 3'd2, 8'h80 + 8'($urandom % 32)));
            emit(immInstr(opStr, 3'd2, base + 8'd1));
            emit(immInstr(opMov, 3'd3, 8'hA0 + 8'($urandom % 32)));
            emit(regInstr(opAltLdr, 3'd4, 3'd3, 3'd0));
            emit(immInstr(opStr, 3'd4, base + 8'd2));
            emit(regInstr(opAltMov, 3'd5, 3'd2, 3'd0));
            emit(immInstr(opStr, 3'd5, base + 8'd3));
            emit(immInstr(opMov, 3'd6, base + 8'd4));
            emit(regInstr(opAltStr, 3'd4, 3'd6, 3'd0));
        end
    endtask

    task automatic buildAlu();
        logic [7:0] base;
        opcode_e    op;
        for (int k = 0; k < 4; k++) begin
            base = 8'(8'hC0 + 8 * k);
            emit(immInstr(opLdr, 3'd1, 8'(8'h80 + 2 * k)));
            emit(immInstr(opLdr, 3'd2, 8'(8'h81 + 2 * k)));
            for (int j = 0; j < 7; j++) begin
                op = opcode_e'(opAdd + 5'(j));
                emit(regInstr(op, 3'd3, 3'd1, 3'd2));
                emit(immInstr(opStr, 3'd3, base + 8'(j)));
            end
        end
    endtask

    // r4 is the taken marker, r5 the fall-through marker
    task automatic buildBranches();
        logic [15:0] x;
        logic [15:0] y;
        logic [15:0] swap;
        logic [7:0]  p;
        opcode_e     brOp;
        emit(immInstr(opMov, 3'd4, 8'h5A));
        emit(immInstr(opMov, 3'd5, 8'hA5));
        for (int i = 0; i < 9; i++) begin
            x = 16'($urandom);
            y = 16'($urandom);
            // pairs cycle through equal, greater, less
            if (i % 3 == 0) begin
                y = x;
            end else if (x == y) begin
                y = x ^ 16'h0001;
            end
            if ((i % 3 == 1 && $signed(x) < $signed(y))
                    || (i % 3 == 2 && $signed(x) > $signed(y))) begin
                swap = x;
                x = y;
                y = swap;
            end
            image[8'(8'h80 + 2 * i)] = x;
            image[8'(8'h81 + 2 * i)] = y;
            brOp = (i / 3 == 0) ? opBgt : ((i / 3 == 1) ? opBlt : opBeq);
            p = 8'(progPos);
            emit(immInstr(opLdr, 3'd1, 8'(8'h80 + 2 * i)));
            emit(immInstr(opLdr, 3'd2, 8'(8'h81 + 2 * i)));
            emit(regInstr(opCmp, 3'd0, 3'd1, 3'd2));
            emit(immInstr(brOp, 3'd0, p + 8'd6));
            emit(immInstr(opStr, 3'd5, 8'(8'hC0 + i)));
            emit(immInstr(opB, 3'd0, p + 8'd7));
            emit(immInstr(opStr, 3'd4, 8'(8'hC0 + i)));
        end
    endtask

    task automatic buildJumps();
        logic [7:0] p;
        emit(immInstr(opNop, 3'd0, 8'd0));
        emit(immInstr(opMov, 3'd1, 8'($urandom)));
        emit(immInstr(opNop, 3'd0, 8'd0));
        p = 8'(progPos);
        // 0xC0 and 0xC1 keep their fill
        emit(immInstr(opB, 3'd0, p + 8'd3));
        emit(immInstr(opStr, 3'd1, 8'hC0));
        emit(immInstr(opStr, 3'd1, 8'hC1));
        emit(immInstr(opStr, 3'd1, 8'hC2));
    endtask

    task automatic buildProgram(input int t);
        for (int a = 0; a < memWords; a++) begin
            image[addrWidth'(a)] = 16'($urandom);
        end
        progPos = 0;
        case (t)
            1:       buildMoves();
            2:       buildAlu();
            3:       buildBranches();
            4:       buildJumps();
            default: ;
        endcase
        if (t != 0) begin
            emit(immInstr(opHalt, 3'd0, 8'd0));
        end
    endtask

    task automatic applyReset();
        @(negedge clk);
        reset = 1'b1;
        run = 1'b0;
        repeat (resetCycles) @(negedge clk);
        reset = 1'b0;
    endtask

    // setup, access, then idle
    task automatic apbTransfer(input logic write, input logic [addrWidth-1:0] addr,
            input logic [dataWidth-1:0] data);
        @(negedge clk);
        pSel = 1'b1;
        pEnable = 1'b0;
        pWrite = write;
        pAddr = addr;
        pWData = data;
        @(negedge clk);
        pEnable = 1'b1;
        @(negedge clk);
        pSel = 1'b0;
        pEnable = 1'b0;
    endtask

    task automatic runAndWait(input int steps);
        int limit;
        int waited;
        limit = steps * cyclesPerInstr + 20;
        waited = 0;
        @(negedge clk);
        run = 1'b1;
        while (!halted && waited < limit) begin
            @(negedge clk);
            waited++;
        end
        if (!halted) begin
            $display("halted did not rise in test %0d within %0d cycles", testId, limit);
            missingHalts++;
            run = 1'b0;
        end
    endtask

    initial begin
        int steps;
        reset = 1'b1;
        run = 1'b0;
        pSel = 1'b0;
        pEnable = 1'b0;
        pWrite = 1'b0;
        pAddr = '0;
        pWData = '0;
        testId = 0;
        missingHalts = 0;
        progPos = 0;
        void'($urandom(67393));
        for (int t = 0; t < numTests; t++) begin
            testId = t;
            buildProgram(t);
            applyReset();
            for (int a = 0; a < memWords; a++) begin
                apbTransfer(1'b1, addrWidth'(a), image[addrWidth'(a)]);
            end
            for (int a = 0; a < memWords; a++) begin
                expMem[addrWidth'(a)] = image[addrWidth'(a)];
            end
            // test 0 only checks the APB round trip
            if (t != 0) begin
                steps = runModel();
                runAndWait(steps);
            end
            for (int a = 0; a < memWords; a++) begin
                apbTransfer(1'b0, addrWidth'(a), '0);
            end
        end
        if (checkCount != numTests * memWords) begin
            $display("only %0d of %0d words were read back", checkCount,
                     numTests * memWords);
        end
        $display("checks %0d, data errors %0d, other errors %0d, missing halts %0d",
                 checkCount, dataErrors, otherErrors, missingHalts);
        if (dataErrors == 0 && otherErrors == 0 && missingHalts == 0
                && checkCount == numTests * memWords) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule
